// File: logic/drac_ctrl_cfg.svh
/*
 * configuration macros for the pipeline control subsystem
 *   address and instruction widths
 *   program counter value after reset
 *   JAL major opcode
 */

`ifndef DRAC_CTRL_CFG_SVH
`define DRAC_CTRL_CFG_SVH

// datapath widths
`define DRAC_ADDR_W 32
`define DRAC_INST_W 32

// boot address
`define DRAC_RESET_PC 32'h0000_1000

// RV32I jal major opcode
`define DRAC_OPCODE_JAL 7'b1101111

`endif

// File: logic/drac_ctrl_pkg.sv
/*
 * shared types of the pipeline control subsystem
 *   address and instruction vectors
 *   next-pc and fetch address select encodings
 *   stage payload structs and unit summary structs
 *   flush and stall bundle for every stage
 */

`include "drac_ctrl_cfg.svh"

package drac_ctrl_pkg;

    typedef logic [`DRAC_ADDR_W-1:0] addr_t;
    typedef logic [`DRAC_INST_W-1:0] inst_t;

    // how fetch builds the next pc
    typedef enum logic [1:0] {
        NEXT_PC_SEL_PC   = 2'b00,
        NEXT_PC_SEL_PC_4 = 2'b01,
        NEXT_PC_SEL_JUMP = 2'b10
    } next_pc_sel_t;

    // which jump target feeds fetch
    typedef enum logic {
        SEL_JUMP_DECODE = 1'b0,
        SEL_JUMP_COMMIT = 1'b1
    } sel_addr_t;

    // IF/ID payload
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } if_id_t;

    // ID/RR payload, jal marks a decoded jump
    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  jal;
    } id_rr_t;

    // decode summary toward control
    typedef struct packed {
        logic  valid_jal;
        addr_t jal_target;
    } id_cu_t;

    // execute summary
    typedef struct packed {
        logic stall;
    } exe_cu_t;

    // write-back summary, branch already resolved
    typedef struct packed {
        logic  valid;
        logic  change_pc_ena;
        logic  branch_taken;
        addr_t branch_target;
    } wb_cu_t;

    // control toward fetch
    typedef struct packed {
        next_pc_sel_t next_pc;
    } cu_if_t;

    // per-stage flush and stall plus fetch address source
    typedef struct packed {
        sel_addr_t sel_addr_if;
        logic      flush_if;
        logic      flush_id;
        logic      flush_rr;
        logic      flush_exe;
        logic      flush_wb;
        logic      stall_if;
        logic      stall_id;
        logic      stall_rr;
        logic      stall_exe;
        logic      stall_wb;
    } pipeline_ctrl_t;

endpackage

// File: logic/control_unit.sv
/*
 * pipeline control unit
 *   jump enable from write-back and decode
 *   next-pc choice and fetch address source
 *   per-stage flush and stall generation
 */

`timescale 1ns/1ps

module control_unit (
    // clock and reset only sampled by bound checks
    input  logic                          clk_i,
    input  logic                          reset_i,

    input  logic                          valid_fetch_i,
    input  drac_ctrl_pkg::id_cu_t         id_cu_i,
    input  drac_ctrl_pkg::exe_cu_t        exe_cu_i,
    input  drac_ctrl_pkg::wb_cu_t         wb_cu_i,

    output drac_ctrl_pkg::pipeline_ctrl_t pipeline_ctrl_o,
    output drac_ctrl_pkg::cu_if_t         cu_if_o
);

    // taken branch resolved at write-back
    logic commit_taken;
    // taken branch that is allowed to move the pc
    logic commit_jump;
    // any source redirects fetch
    logic jump_ena;
    // execute back-pressure
    logic stall_all;

    assign commit_taken = wb_cu_i.valid & wb_cu_i.branch_taken;
    assign commit_jump  = commit_taken & wb_cu_i.change_pc_ena;
    assign jump_ena     = commit_jump | id_cu_i.valid_jal;
    assign stall_all    = exe_cu_i.stall;

    // next pc, a jump overrides stall and idle fetch
    always_comb begin
        if (jump_ena) begin
            cu_if_o.next_pc = drac_ctrl_pkg::NEXT_PC_SEL_JUMP;
        end else if (!valid_fetch_i || stall_all) begin
            // memory keeps seeing the same pc
            cu_if_o.next_pc = drac_ctrl_pkg::NEXT_PC_SEL_PC;
        end else begin
            cu_if_o.next_pc = drac_ctrl_pkg::NEXT_PC_SEL_PC_4;
        end
    end

    // commit target wins over the decode target
    always_comb begin
        if (commit_taken) begin
            pipeline_ctrl_o.sel_addr_if = drac_ctrl_pkg::SEL_JUMP_COMMIT;
        end else begin
            pipeline_ctrl_o.sel_addr_if = drac_ctrl_pkg::SEL_JUMP_DECODE;
        end
    end

    // flushes
    always_comb begin
        // jal only kills the instruction fetched in its shadow
        pipeline_ctrl_o.flush_if  = commit_taken | id_cu_i.valid_jal;
        // write-back redirect drains everything younger
        pipeline_ctrl_o.flush_id  = commit_taken;
        pipeline_ctrl_o.flush_rr  = commit_taken;
        pipeline_ctrl_o.flush_exe = commit_taken;
        // retiring instruction always completes
        pipeline_ctrl_o.flush_wb  = 1'b0;
    end

    // stalls, execute holds every older-facing stage
    always_comb begin
        pipeline_ctrl_o.stall_if  = stall_all;
        pipeline_ctrl_o.stall_id  = stall_all;
        pipeline_ctrl_o.stall_rr  = stall_all;
        pipeline_ctrl_o.stall_exe = stall_all;
        pipeline_ctrl_o.stall_wb  = 1'b0;
    end

endmodule

// File: logic/pc_gen.sv
/*
 * program counter generator
 *   pc register loaded with the boot address on reset
 *   next-pc mux for hold, sequential step and jump
 *   jump target select between decode and commit
 */

`timescale 1ns/1ps

`include "drac_ctrl_cfg.svh"

module pc_gen (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  drac_ctrl_pkg::cu_if_t     cu_if_i,
    input  drac_ctrl_pkg::sel_addr_t  sel_addr_i,
    input  drac_ctrl_pkg::addr_t      jump_decode_i,
    input  drac_ctrl_pkg::addr_t      jump_commit_i,

    output drac_ctrl_pkg::addr_t      pc_o
);

    drac_ctrl_pkg::addr_t pc_q;
    drac_ctrl_pkg::addr_t pc_d;
    drac_ctrl_pkg::addr_t jump_addr;

    // target of a taken redirect
    assign jump_addr = (sel_addr_i == drac_ctrl_pkg::SEL_JUMP_COMMIT) ?
                       jump_commit_i : jump_decode_i;

    // stall is already folded into next_pc by control
    always_comb begin
        case (cu_if_i.next_pc)
            drac_ctrl_pkg::NEXT_PC_SEL_PC_4: pc_d = pc_q + 'd4;
            drac_ctrl_pkg::NEXT_PC_SEL_JUMP: pc_d = jump_addr;
            default:                         pc_d = pc_q;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= `DRAC_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // registered pc goes straight to memory
    assign pc_o = pc_q;

endmodule

// File: logic/pipe_stage.sv
/*
 * generic pipeline register
 *   valid bit cleared by reset and flush
 *   valid and payload held while stalled
 *   payload type given as a type parameter
 */

`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,

    input  logic     valid_i,
    input  payload_t data_i,
    input  logic     flush_i,
    input  logic     stall_i,

    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // flush checked first, it beats stall
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i;
        end
    end

    // payload only meaningful with valid set
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// File: logic/jal_decoder.sv
/*
 * JAL decoder for the decode stage
 *   opcode match against the JAL opcode
 *   J-type immediate and jump target
 *   payload forward with jal flag
 */

`timescale 1ns/1ps

`include "drac_ctrl_cfg.svh"

module jal_decoder (
    input  logic                   if_id_valid_i,
    input  drac_ctrl_pkg::if_id_t  if_id_i,

    output drac_ctrl_pkg::id_cu_t  id_cu_o,
    output drac_ctrl_pkg::id_rr_t  id_rr_o
);

    logic                 is_jal;
    drac_ctrl_pkg::addr_t imm_j;

    // major opcode in the low 7 bits
    assign is_jal = (if_id_i.inst[6:0] == `DRAC_OPCODE_JAL);

    // J-type: imm[20|10:1|11|19:12], bit 0 always zero
    assign imm_j = {{(`DRAC_ADDR_W-20){if_id_i.inst[31]}},
                    if_id_i.inst[19:12],
                    if_id_i.inst[20],
                    if_id_i.inst[30:21],
                    1'b0};

    // summary toward control, only for a live entry
    assign id_cu_o.valid_jal  = if_id_valid_i & is_jal;
    assign id_cu_o.jal_target = if_id_i.pc + imm_j;

    // payload for register read
    assign id_rr_o.pc   = if_id_i.pc;
    assign id_rr_o.inst = if_id_i.inst;
    assign id_rr_o.jal  = is_jal;

endmodule

// File: logic/drac_ctrl_top.sv
/*
 * front end and pipeline control top level
 *   control unit and pc generator
 *   IF/ID and ID/RR pipeline registers
 *   JAL decoder between the two registers
 */

`timescale 1ns/1ps

module drac_ctrl_top (
    input  logic                          clk_i,
    input  logic                          reset_i,

    // instruction memory response
    input  logic                          valid_fetch_i,
    input  drac_ctrl_pkg::inst_t          fetch_inst_i,

    // outside execute and write-back
    input  drac_ctrl_pkg::exe_cu_t        exe_cu_i,
    input  drac_ctrl_pkg::wb_cu_t         wb_cu_i,

    output drac_ctrl_pkg::addr_t          fetch_pc_o,
    output logic                          id_rr_valid_o,
    output drac_ctrl_pkg::id_rr_t         id_rr_o,
    output drac_ctrl_pkg::pipeline_ctrl_t pipeline_ctrl_o
);

    drac_ctrl_pkg::cu_if_t         cu_if;
    drac_ctrl_pkg::pipeline_ctrl_t pipeline_ctrl;
    drac_ctrl_pkg::id_cu_t         id_cu;
    drac_ctrl_pkg::addr_t          fetch_pc;
    drac_ctrl_pkg::if_id_t         if_id_d;
    drac_ctrl_pkg::if_id_t         if_id_q;
    logic                          if_id_valid;
    drac_ctrl_pkg::id_rr_t         id_rr_d;

    control_unit i_control_unit (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .valid_fetch_i   (valid_fetch_i),
        .id_cu_i         (id_cu),
        .exe_cu_i        (exe_cu_i),
        .wb_cu_i         (wb_cu_i),
        .pipeline_ctrl_o (pipeline_ctrl),
        .cu_if_o         (cu_if)
    );

    pc_gen i_pc_gen (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .cu_if_i       (cu_if),
        .sel_addr_i    (pipeline_ctrl.sel_addr_if),
        .jump_decode_i (id_cu.jal_target),
        .jump_commit_i (wb_cu_i.branch_target),
        .pc_o          (fetch_pc)
    );

    // pc paired with the word memory returned for it
    assign if_id_d.pc   = fetch_pc;
    assign if_id_d.inst = fetch_inst_i;

    pipe_stage #(.payload_t(drac_ctrl_pkg::if_id_t)) i_if_id_stage (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_fetch_i),
        .data_i  (if_id_d),
        .flush_i (pipeline_ctrl.flush_if),
        .stall_i (pipeline_ctrl.stall_id),
        .valid_o (if_id_valid),
        .data_o  (if_id_q)
    );

    jal_decoder i_jal_decoder (
        .if_id_valid_i (if_id_valid),
        .if_id_i       (if_id_q),
        .id_cu_o       (id_cu),
        .id_rr_o       (id_rr_d)
    );

    pipe_stage #(.payload_t(drac_ctrl_pkg::id_rr_t)) i_id_rr_stage (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (if_id_valid),
        .data_i  (id_rr_d),
        .flush_i (pipeline_ctrl.flush_id),
        .stall_i (pipeline_ctrl.stall_rr),
        .valid_o (id_rr_valid_o),
        .data_o  (id_rr_o)
    );

    assign fetch_pc_o      = fetch_pc;
    assign pipeline_ctrl_o = pipeline_ctrl;

endmodule

// File: sim/drac_ctrl_properties.sv
/*
 * concurrent checks on the pipeline control bundle
 *   execute flush implies flushes of IF, ID and RR
 *   write-back never stalled or flushed
 *   commit target select comes with a fetch flush
 */

`timescale 1ns/1ps

module drac_ctrl_properties (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  drac_ctrl_pkg::pipeline_ctrl_t pipeline_ctrl_i
);

    // failing assertion count
    int assert_fail_cnt = 0;

    // redirect from write-back drains all younger stages
    flush_exe_drains: assert property (@(posedge clk_i) disable iff (reset_i)
        pipeline_ctrl_i.flush_exe |->
            (pipeline_ctrl_i.flush_if && pipeline_ctrl_i.flush_id && pipeline_ctrl_i.flush_rr))
    else begin
        $error("flush of EXE without flushes of IF, ID and RR");
        assert_fail_cnt = assert_fail_cnt + 1;
    end

    // retiring instruction always completes
    wb_untouched: assert property (@(posedge clk_i) disable iff (reset_i)
        !pipeline_ctrl_i.stall_wb && !pipeline_ctrl_i.flush_wb)
    else begin
        $error("write-back stage was stalled or flushed");
        assert_fail_cnt = assert_fail_cnt + 1;
    end

    commit_flushes_fetch: assert property (@(posedge clk_i) disable iff (reset_i)
        (pipeline_ctrl_i.sel_addr_if == drac_ctrl_pkg::SEL_JUMP_COMMIT) |->
            pipeline_ctrl_i.flush_if)
    else begin
        $error("commit target selected without a fetch flush");
        assert_fail_cnt = assert_fail_cnt + 1;
    end

endmodule

bind control_unit drac_ctrl_properties i_drac_ctrl_properties (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .pipeline_ctrl_i (pipeline_ctrl_o)
);

// File: sim/tb_drac_ctrl.sv
/*
 * testbench for the front end and pipeline control top level
 *   clock, reset and per-cycle vectors from the stimulus file
 *   compare tasks for fetch pc, control bundle and ID/RR output
 *   per-test report, closing counts and cycle watchdog
 */

`timescale 1ns/1ps

module tb_drac_ctrl;

    // one cycle of inputs with the responses expected in it
    typedef struct packed {
        logic [7:0]                    test;
        logic                          valid_fetch;
        drac_ctrl_pkg::inst_t          inst;
        drac_ctrl_pkg::exe_cu_t        exe_cu;
        drac_ctrl_pkg::wb_cu_t         wb_cu;
        drac_ctrl_pkg::addr_t          exp_pc;
        drac_ctrl_pkg::pipeline_ctrl_t exp_ctrl;
        logic                          exp_valid;
        drac_ctrl_pkg::id_rr_t         exp_id_rr;
    } vector_t;

    logic                          clk;
    logic                          reset;
    logic                          valid_fetch;
    drac_ctrl_pkg::inst_t          fetch_inst;
    drac_ctrl_pkg::exe_cu_t        exe_cu;
    drac_ctrl_pkg::wb_cu_t         wb_cu;
    drac_ctrl_pkg::addr_t          fetch_pc;
    logic                          id_rr_valid;
    drac_ctrl_pkg::id_rr_t         id_rr;
    drac_ctrl_pkg::pipeline_ctrl_t pipeline_ctrl;

    vector_t    vectors[$];
    logic [7:0] cur_test;
    int         cur_cycle;
    int         check_cnt;
    int         err_cnt;
    int         test_checks;
    int         test_errs;
    int         cycle_cnt;
    int         cycle_limit;
    int         assert_fails;
    bit         load_ok;
    bit         run_done;

    drac_ctrl_top i_drac_ctrl_top (
        .clk_i           (clk),
        .reset_i         (reset),
        .valid_fetch_i   (valid_fetch),
        .fetch_inst_i    (fetch_inst),
        .exe_cu_i        (exe_cu),
        .wb_cu_i         (wb_cu),
        .fetch_pc_o      (fetch_pc),
        .id_rr_valid_o   (id_rr_valid),
        .id_rr_o         (id_rr),
        .pipeline_ctrl_o (pipeline_ctrl)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // watchdog, limit set once the vectors are known
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!run_done && cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic string test_name(logic [7:0] num);
        case (num)
            8'd1:    return "reset state";
            8'd2:    return "sequential fetch";
            8'd3:    return "hold and stall";
            8'd4:    return "jal redirect";
            8'd5:    return "write-back redirect";
            default: return "unnamed";
        endcase
    endfunction

    // comment and blank lines skipped, anything else must parse
    task automatic load_vectors(output bit ok);
        int                   fd;
        int                   fields;
        int                   bad_lines;
        int                   t;
        string                line;
        logic                 vf, st, wv, wc, wt, ev, ej;
        logic [31:0]          inst, wtgt, epc, erpc, erinst;
        logic [10:0]          ectrl;
        vector_t              v;
        ok = 1'b0;
        bad_lines = 0;
        fd = $fopen("sim/drac_ctrl_stimulus.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 t, vf, inst, st, wv, wc, wt, wtgt,
                                 epc, ectrl, ev, erpc, erinst, ej);
                if (fields == 14) begin
                    v.test                = t[7:0];
                    v.valid_fetch         = vf;
                    v.inst                = inst;
                    v.exe_cu.stall        = st;
                    v.wb_cu.valid         = wv;
                    v.wb_cu.change_pc_ena = wc;
                    v.wb_cu.branch_taken  = wt;
                    v.wb_cu.branch_target = wtgt;
                    v.exp_pc              = epc;
                    v.exp_ctrl            = drac_ctrl_pkg::pipeline_ctrl_t'(ectrl);
                    v.exp_valid           = ev;
                    v.exp_id_rr.pc        = erpc;
                    v.exp_id_rr.inst      = erinst;
                    v.exp_id_rr.jal       = ej;
                    vectors.push_back(v);
                end else if (line.len() > 1 && line[0] != "#") begin
                    $display("stimulus line could not be parsed: %s", line);
                    bad_lines = bad_lines + 1;
                end
            end
            $fclose(fd);
            ok = (bad_lines == 0) && (vectors.size() > 0);
        end
    endtask

    task automatic count_check(input bit failed);
        check_cnt   = check_cnt + 1;
        test_checks = test_checks + 1;
        if (failed) begin
            err_cnt   = err_cnt + 1;
            test_errs = test_errs + 1;
        end
    endtask

    task automatic check_addr(input string name, input drac_ctrl_pkg::addr_t got,
                              input drac_ctrl_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Fail %s at cycle %0d: got %h, expected %h", name, cur_cycle, got, exp);
        end
        count_check(got !== exp);
    endtask

    task automatic check_ctrl(input drac_ctrl_pkg::pipeline_ctrl_t got,
                              input drac_ctrl_pkg::pipeline_ctrl_t exp);
        if (got !== exp) begin
            $display("Fail pipeline_ctrl_o at cycle %0d: got %h, expected %h",
                     cur_cycle, got, exp);
        end
        count_check(got !== exp);
    endtask

    // payload only compared for a valid entry
    task automatic check_id_rr(input logic got_valid, input drac_ctrl_pkg::id_rr_t got,
                               input logic exp_valid, input drac_ctrl_pkg::id_rr_t exp);
        bit failed;
        failed = 1'b0;
        if (got_valid !== exp_valid) begin
            $display("Fail id_rr_valid_o at cycle %0d: got %h, expected %h",
                     cur_cycle, got_valid, exp_valid);
            failed = 1'b1;
        end else if (exp_valid && got !== exp) begin
            $display("Fail id_rr_o at cycle %0d: got %h, expected %h", cur_cycle, got, exp);
            failed = 1'b1;
        end
        count_check(failed);
    endtask

    task automatic apply_vector(input vector_t v);
        valid_fetch = v.valid_fetch;
        fetch_inst  = v.inst;
        exe_cu      = v.exe_cu;
        wb_cu       = v.wb_cu;
    endtask

    task automatic report_test(input logic [7:0] num);
        $display("test %0d (%s) finished: %0d checks, %0d errors",
                 num, test_name(num), test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        valid_fetch = 1'b0;
        fetch_inst  = '0;
        exe_cu      = '0;
        wb_cu       = '0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        run_done    = 1'b0;
        load_vectors(load_ok);
        if (!load_ok) begin
            $display("stimulus file missing, malformed or empty");
            $display("Simulation failed");
            $finish;
        end else begin
            cycle_limit = vectors.size() + 50;
            repeat (5) @(posedge clk);
            #2;
            reset    = 1'b0;
            cur_test = vectors[0].test;
            foreach (vectors[i]) begin
                if (vectors[i].test != cur_test) begin
                    report_test(cur_test);
                    cur_test = vectors[i].test;
                end
                cur_cycle = i + 1;
                apply_vector(vectors[i]);
                // registered and combinational outputs settled mid-cycle
                @(negedge clk);
                check_addr("fetch_pc_o", fetch_pc, vectors[i].exp_pc);
                check_ctrl(pipeline_ctrl, vectors[i].exp_ctrl);
                check_id_rr(id_rr_valid, id_rr, vectors[i].exp_valid, vectors[i].exp_id_rr);
                @(posedge clk);
                #2;
            end
            report_test(cur_test);
            run_done     = 1'b1;
            assert_fails = i_drac_ctrl_top.i_control_unit.i_drac_ctrl_properties.assert_fail_cnt;
            $display("checks: %0d, errors: %0d, assertion failures: %0d",
                     check_cnt, err_cnt, assert_fails);
            if (err_cnt == 0 && assert_fails == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

// File: drac_ctrl.f
+incdir+logic
logic/drac_ctrl_pkg.sv
logic/control_unit.sv
logic/pc_gen.sv
logic/pipe_stage.sv
logic/jal_decoder.sv
logic/drac_ctrl_top.sv
sim/drac_ctrl_properties.sv
sim/tb_drac_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the pipeline control testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f drac_ctrl.f \
    --top-module tb_drac_ctrl \
    --Mdir obj_dir \
    -o sim_drac_ctrl

# raised error limit so assertion failures reach the testbench summary
./obj_dir/sim_drac_ctrl +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim: failure reported, see sim.log"
    exit 1
fi

echo "run_sim: no failure reported"

// File: sim/drac_ctrl_stimulus.txt
# in:  test valid_fetch inst stall wb_valid wb_change_pc wb_taken wb_target
# out: fetch_pc pipeline_ctrl id_rr_valid id_rr_pc id_rr_inst id_rr_jal (hex, test decimal)
# 1 reset state, idle inputs
1 0 00000000 0 0 0 0 00000000 00001000 000 0 00000000 00000000 0
1 0 00000000 0 0 0 0 00000000 00001000 000 0 00000000 00000000 0
# 2 sequential fetch, each word reaches ID/RR two cycles later
2 1 00100093 0 0 0 0 00000000 00001000 000 0 00000000 00000000 0
2 1 00200113 0 0 0 0 00000000 00001004 000 0 00000000 00000000 0
2 1 00300193 0 0 0 0 00000000 00001008 000 1 00001000 00100093 0
# 3 execute stall for two cycles, then a fetch gap
3 1 00400213 1 0 0 0 00000000 0000100c 01e 1 00001004 00200113 0
3 1 00400213 1 0 0 0 00000000 0000100c 01e 1 00001004 00200113 0
3 1 00400213 0 0 0 0 00000000 0000100c 000 1 00001004 00200113 0
3 0 00000000 0 0 0 0 00000000 00001010 000 1 00001008 00300193 0
3 0 00000000 0 0 0 0 00000000 00001010 000 1 0000100c 00400213 0
# 4 jal +0x20 then jal -0x10, shadow words dropped
4 1 020000ef 0 0 0 0 00000000 00001010 000 0 00000000 00000000 0
4 1 00600313 0 0 0 0 00000000 00001014 200 0 00000000 00000000 0
4 1 ff1ff06f 0 0 0 0 00000000 00001030 000 1 00001010 020000ef 1
4 1 00700393 0 0 0 0 00000000 00001034 200 0 00000000 00000000 0
4 0 00000000 0 0 0 0 00000000 00001020 000 1 00001030 ff1ff06f 1
# 5 taken branch from write-back, alone and against jal plus stall
5 1 00800413 0 0 0 0 00000000 00001020 000 0 00000000 00000000 0
5 1 00900493 0 0 0 0 00000000 00001024 000 0 00000000 00000000 0
5 1 00a00513 0 1 1 1 00002000 00001028 7c0 1 00001020 00800413 0
5 1 00b00593 0 0 0 0 00000000 00002000 000 0 00000000 00000000 0
5 1 020000ef 0 0 0 0 00000000 00002004 000 0 00000000 00000000 0
5 1 00c00613 1 1 1 1 00003000 00002008 7de 1 00002000 00b00593 0
# not-taken branch leaves fetch alone
5 0 00000000 0 1 1 0 00004000 00003000 000 0 00000000 00000000 0
5 1 00d00693 0 0 0 0 00000000 00003000 000 0 00000000 00000000 0
5 0 00000000 0 0 0 0 00000000 00003004 000 0 00000000 00000000 0
5 0 00000000 0 0 0 0 00000000 00003004 000 1 00003000 00d00693 0
